/* hdl/wb_pkg.sv */
package wb_pkg;

	typedef logic [31:0] word;
	typedef logic [3:0] reg_num;

	// Link register and program counter.
	localparam reg_num R14 = 4'd14;
	localparam reg_num R15 = 4'd15;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} psr_flags;

	typedef enum logic [2:0] {
		OP_ADD,
		OP_SUB,
		OP_LOAD,
		OP_STORE,
		OP_MULL,
		OP_SWI
	} op_kind;

	// One value per control cycle of the multi-cycle core.
	typedef enum logic [2:0] {
		IDLE,
		ISSUE,
		TRANSFER,
		BASE_WRITEBACK,
		MUL,
		MUL_HI_WB,
		EXCEPTION
	} ctrl_cycle;

endpackage

/* hdl/op_intake.sv */
`timescale 1ns/1ps

module op_intake (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            req,
	input  wb_pkg::op_kind  kind,
	input  wb_pkg::reg_num  rd,
	input  wb_pkg::reg_num  ra,
	input  wb_pkg::reg_num  rd_hi,
	input  wb_pkg::word     op_a,
	input  wb_pkg::word     op_b,
	input  logic            set_flags,
	input  logic            base_wb,
	input  logic            done,
	output logic            ack,
	output logic            start,
	output wb_pkg::op_kind  k_kind,
	output wb_pkg::reg_num  k_rd,
	output wb_pkg::reg_num  k_ra,
	output wb_pkg::reg_num  k_rd_hi,
	output wb_pkg::word     k_a,
	output wb_pkg::word     k_b,
	output logic            k_set_flags,
	output logic            k_base_wb
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_BUSY,
		S_ACKED
	} hs_state;

	hs_state state;
	logic    take;

	assign take = (state == S_IDLE) && req;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			start <= 1'b0;
			ack   <= 1'b0;
		end else begin
			start <= 1'b0;
			case (state)
				S_IDLE:
					if (req) begin
						state <= S_BUSY;
						start <= 1'b1;
					end
				S_BUSY:
					if (done) begin
						state <= S_ACKED;
						ack   <= 1'b1;
					end
				// Hold ack until the sender drops req.
				S_ACKED:
					if (!req) begin
						state <= S_IDLE;
						ack   <= 1'b0;
					end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			k_kind      <= kind;
			k_rd        <= rd;
			k_ra        <= ra;
			k_rd_hi     <= rd_hi;
			k_a         <= op_a;
			k_b         <= op_b;
			k_set_flags <= set_flags;
			k_base_wb   <= base_wb;
		end
	end

endmodule

/* hdl/exec_sequencer.sv */
`timescale 1ns/1ps

module exec_sequencer (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              start,
	input  wb_pkg::op_kind    k_kind,
	input  wb_pkg::word       k_a,
	input  wb_pkg::word       k_b,
	input  logic              k_base_wb,
	input  logic              mem_ready,
	input  wb_pkg::psr_flags  flags_in,
	output wb_pkg::ctrl_cycle cycle,
	output wb_pkg::ctrl_cycle next_cycle,
	output wb_pkg::word       q_alu,
	output wb_pkg::word       mul_q_hi,
	output wb_pkg::word       mul_q_lo,
	output wb_pkg::word       mem_addr,
	output wb_pkg::psr_flags  alu_flags,
	output logic              mem_req,
	output logic              mem_write,
	output logic              done
);

	import wb_pkg::*;

	logic        is_sub;
	word         b_eff;
	logic [32:0] sum;

	always_comb begin
		case (cycle)
			IDLE:
				next_cycle = start ? ISSUE : IDLE;
			ISSUE:
				case (k_kind)
					OP_LOAD, OP_STORE: next_cycle = TRANSFER;
					OP_MULL:           next_cycle = MUL;
					OP_SWI:            next_cycle = EXCEPTION;
					default:           next_cycle = IDLE;
				endcase
			// Stall here until the RAM answers.
			TRANSFER:
				if (mem_ready)
					next_cycle = k_base_wb ? BASE_WRITEBACK : IDLE;
				else
					next_cycle = TRANSFER;
			MUL:
				next_cycle = MUL_HI_WB;
			default:
				next_cycle = IDLE;
		endcase
	end

	// Subtract as a + ~b + 1 so C is the ARM not-borrow.
	assign is_sub = (k_kind == OP_SUB);
	assign b_eff  = is_sub ? ~k_b : k_b;
	assign sum    = {1'b0, k_a} + {1'b0, b_eff} + {32'd0, is_sub};

	assign mem_addr = sum[31:0];
	assign q_alu    = (k_kind == OP_SWI) ? k_a : sum[31:0];

	always_comb begin
		alu_flags = flags_in;
		if (k_kind == OP_ADD || is_sub) begin
			alu_flags.n = sum[31];
			alu_flags.z = (sum[31:0] == '0);
			alu_flags.c = sum[32];
			alu_flags.v = (k_a[31] == b_eff[31]) && (sum[31] != k_a[31]);
		end
	end

	assign mem_req   = (cycle == TRANSFER);
	assign mem_write = (k_kind == OP_STORE);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cycle <= IDLE;
			done  <= 1'b0;
		end else begin
			cycle <= next_cycle;
			done  <= (cycle != IDLE) && (next_cycle == IDLE);
		end
	end

	// Unsigned product, valid through MUL and MUL_HI_WB.
	always_ff @(posedge clk) begin
		if (next_cycle == MUL)
			{mul_q_hi, mul_q_lo} <= 64'(k_a) * 64'(k_b);
	end

endmodule

/* hdl/writeback_control.sv */
`timescale 1ns/1ps

module writeback_control #(
	parameter wb_pkg::word VECTOR = 32'h0000_0008
) (
	input  logic              clk,
	input  logic              rst_n,
	input  wb_pkg::ctrl_cycle cycle,
	input  wb_pkg::ctrl_cycle next_cycle,
	input  wb_pkg::op_kind    k_kind,
	input  wb_pkg::reg_num    k_rd,
	input  wb_pkg::reg_num    k_ra,
	input  wb_pkg::reg_num    k_rd_hi,
	input  logic              k_set_flags,
	input  logic              start,
	input  wb_pkg::word       q_alu,
	input  wb_pkg::word       mem_data_rd,
	input  wb_pkg::word       mul_q_hi,
	input  wb_pkg::word       mul_q_lo,
	input  wb_pkg::word       saved_base,
	input  wb_pkg::psr_flags  alu_flags,
	input  logic              mem_ready,
	input  logic              mem_write,
	output wb_pkg::reg_num    rd,
	output logic              writeback,
	output logic              update_flags,
	output wb_pkg::word       wr_value,
	output wb_pkg::psr_flags  wb_alu_flags
);

	import wb_pkg::*;

	reg_num final_rd;
	logic   final_writeback;
	logic   final_update_flags;
	logic   is_alu;

	assign is_alu = (k_kind == OP_ADD) || (k_kind == OP_SUB);

	always_comb begin
		rd        = final_rd;
		writeback = 1'b0;
		wr_value  = q_alu;

		case (cycle)
			ISSUE, EXCEPTION:
				writeback = final_writeback;
			TRANSFER: begin
				writeback = mem_ready && !mem_write;
				wr_value  = mem_data_rd;
			end
			BASE_WRITEBACK: begin
				writeback = 1'b1;
				wr_value  = saved_base;
			end
			MUL: begin
				writeback = 1'b1;
				wr_value  = mul_q_lo;
			end
			MUL_HI_WB: begin
				rd        = k_rd_hi;
				writeback = 1'b1;
				wr_value  = mul_q_hi;
			end
			default: ;
		endcase

		// PC takes the vector on the way into EXCEPTION, r14 follows.
		if (next_cycle == EXCEPTION) begin
			rd        = R15;
			writeback = 1'b1;
			wr_value  = VECTOR;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			final_rd           <= '0;
			final_writeback    <= 1'b0;
			final_update_flags <= 1'b0;
			update_flags       <= 1'b0;
			wb_alu_flags       <= '0;
		end else begin
			wb_alu_flags <= alu_flags;
			update_flags <= (cycle == ISSUE) && final_update_flags;

			case (next_cycle)
				ISSUE: begin
					final_rd           <= k_rd;
					final_writeback    <= start && is_alu;
					final_update_flags <= start && is_alu && k_set_flags;
				end
				BASE_WRITEBACK:
					final_rd <= k_ra;
				EXCEPTION: begin
					final_rd           <= R14;
					final_writeback    <= 1'b1;
					final_update_flags <= 1'b0;
				end
				default: ;
			endcase
		end
	end

endmodule

/* hdl/data_ram.sv */
`timescale 1ns/1ps

module data_ram #(
	parameter int RAM_WORDS   = 64,
	parameter int WAIT_STATES = 2
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        mem_req,
	input  logic        mem_write,
	input  wb_pkg::word mem_addr,
	input  wb_pkg::word wr_data,
	output logic        mem_ready,
	output wb_pkg::word mem_data_rd
);

	import wb_pkg::*;

	localparam int AW = $clog2(RAM_WORDS);
	localparam int CW = $clog2(WAIT_STATES + 2);

	word           mem [RAM_WORDS];
	logic [AW-1:0] idx;
	logic [CW-1:0] wait_cnt;

	assign idx         = AW'(mem_addr % RAM_WORDS);
	assign mem_ready   = mem_req && (wait_cnt == '0);
	assign mem_data_rd = mem[idx];

	// Reloaded while idle, counts down during a request.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wait_cnt <= CW'(WAIT_STATES);
		else if (!mem_req)
			wait_cnt <= CW'(WAIT_STATES);
		else if (wait_cnt != '0)
			wait_cnt <= wait_cnt - 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < RAM_WORDS; i++)
				mem[i] <= '0;
		end else if (mem_ready && mem_write) begin
			mem[idx] <= wr_data;
		end
	end

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             writeback,
	input  wb_pkg::reg_num   rd,
	input  wb_pkg::word      wr_value,
	input  logic             update_flags,
	input  wb_pkg::psr_flags wb_alu_flags,
	input  wb_pkg::reg_num   src,
	input  wb_pkg::reg_num   dbg_addr,
	output wb_pkg::word      src_value,
	output wb_pkg::word      dbg_data,
	output wb_pkg::psr_flags flags
);

	import wb_pkg::*;

	word regs [16];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
			flags <= '0;
		end else begin
			if (writeback)
				regs[rd] <= wr_value;
			if (update_flags)
				flags <= wb_alu_flags;
		end
	end

	// Store data and debug port.
	assign src_value = regs[src];
	assign dbg_data  = regs[dbg_addr];

endmodule

/* hdl/wb_top.sv */
`timescale 1ns/1ps

module wb_top #(
	parameter int          RAM_WORDS   = 64,
	parameter int          WAIT_STATES = 2,
	parameter wb_pkg::word VECTOR      = 32'h0000_0008
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             req,
	output logic             ack,
	input  wb_pkg::op_kind   kind,
	input  wb_pkg::reg_num   rd,
	input  wb_pkg::reg_num   ra,
	input  wb_pkg::reg_num   rd_hi,
	input  wb_pkg::word      op_a,
	input  wb_pkg::word      op_b,
	input  logic             set_flags,
	input  logic             base_wb,
	input  wb_pkg::reg_num   dbg_addr,
	output wb_pkg::word      dbg_data,
	output wb_pkg::psr_flags flags
);

	import wb_pkg::*;

	logic      start;
	logic      done;
	op_kind    k_kind;
	reg_num    k_rd;
	reg_num    k_ra;
	reg_num    k_rd_hi;
	word       k_a;
	word       k_b;
	logic      k_set_flags;
	logic      k_base_wb;
	ctrl_cycle cycle;
	ctrl_cycle next_cycle;
	word       q_alu;
	word       mul_q_hi;
	word       mul_q_lo;
	word       mem_addr;
	psr_flags  alu_flags;
	logic      mem_req;
	logic      mem_write;
	logic      mem_ready;
	word       mem_data_rd;
	reg_num    wb_rd;
	logic      writeback;
	logic      update_flags;
	word       wr_value;
	psr_flags  wb_alu_flags;
	word       src_value;

	op_intake u_op_intake (
		.clk         (clk),
		.rst_n       (rst_n),
		.req         (req),
		.kind        (kind),
		.rd          (rd),
		.ra          (ra),
		.rd_hi       (rd_hi),
		.op_a        (op_a),
		.op_b        (op_b),
		.set_flags   (set_flags),
		.base_wb     (base_wb),
		.done        (done),
		.ack         (ack),
		.start       (start),
		.k_kind      (k_kind),
		.k_rd        (k_rd),
		.k_ra        (k_ra),
		.k_rd_hi     (k_rd_hi),
		.k_a         (k_a),
		.k_b         (k_b),
		.k_set_flags (k_set_flags),
		.k_base_wb   (k_base_wb)
	);

	exec_sequencer u_exec_sequencer (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.k_kind     (k_kind),
		.k_a        (k_a),
		.k_b        (k_b),
		.k_base_wb  (k_base_wb),
		.mem_ready  (mem_ready),
		.flags_in   (flags),
		.cycle      (cycle),
		.next_cycle (next_cycle),
		.q_alu      (q_alu),
		.mul_q_hi   (mul_q_hi),
		.mul_q_lo   (mul_q_lo),
		.mem_addr   (mem_addr),
		.alu_flags  (alu_flags),
		.mem_req    (mem_req),
		.mem_write  (mem_write),
		.done       (done)
	);

	// The generated address doubles as the updated base.
	writeback_control #(
		.VECTOR (VECTOR)
	) u_writeback_control (
		.clk          (clk),
		.rst_n        (rst_n),
		.cycle        (cycle),
		.next_cycle   (next_cycle),
		.k_kind       (k_kind),
		.k_rd         (k_rd),
		.k_ra         (k_ra),
		.k_rd_hi      (k_rd_hi),
		.k_set_flags  (k_set_flags),
		.start        (start),
		.q_alu        (q_alu),
		.mem_data_rd  (mem_data_rd),
		.mul_q_hi     (mul_q_hi),
		.mul_q_lo     (mul_q_lo),
		.saved_base   (mem_addr),
		.alu_flags    (alu_flags),
		.mem_ready    (mem_ready),
		.mem_write    (mem_write),
		.rd           (wb_rd),
		.writeback    (writeback),
		.update_flags (update_flags),
		.wr_value     (wr_value),
		.wb_alu_flags (wb_alu_flags)
	);

	data_ram #(
		.RAM_WORDS   (RAM_WORDS),
		.WAIT_STATES (WAIT_STATES)
	) u_data_ram (
		.clk         (clk),
		.rst_n       (rst_n),
		.mem_req     (mem_req),
		.mem_write   (mem_write),
		.mem_addr    (mem_addr),
		.wr_data     (src_value),
		.mem_ready   (mem_ready),
		.mem_data_rd (mem_data_rd)
	);

	reg_file u_reg_file (
		.clk          (clk),
		.rst_n        (rst_n),
		.writeback    (writeback),
		.rd           (wb_rd),
		.wr_value     (wr_value),
		.update_flags (update_flags),
		.wb_alu_flags (wb_alu_flags),
		.src          (k_rd),
		.dbg_addr     (dbg_addr),
		.src_value    (src_value),
		.dbg_data     (dbg_data),
		.flags        (flags)
	);

endmodule

/* verification/tb_wb.sv */
`timescale 1ns/1ps

module tb_wb;

	import wb_pkg::*;

	localparam int         RAM_WORDS   = 64;
	localparam int         WAIT_STATES = 2;
	localparam word        VECTOR      = 32'h0000_0008;
	localparam logic [2:0] CHECK_ONLY  = 3'd7;

	// One trace line after parsing.
	typedef struct packed {
		logic [7:0] gap;
		logic [2:0] kind;
		reg_num     rd;
		reg_num     ra;
		reg_num     rd_hi;
		word        a;
		word        b;
		logic       set_flags;
		logic       base_wb;
		logic [1:0] n_chk;
		reg_num     chk0_reg;
		word        chk0_val;
		reg_num     chk1_reg;
		word        chk1_val;
		psr_flags   exp_flags;
	} trace_line;

	logic      clk;
	logic      rst_n;
	logic      req;
	logic      ack;
	op_kind    kind;
	reg_num    rd;
	reg_num    ra;
	reg_num    rd_hi;
	word       op_a;
	word       op_b;
	logic      set_flags;
	logic      base_wb;
	reg_num    dbg_addr;
	word       dbg_data;
	psr_flags  flags;

	trace_line trace [$];
	int        value_errors;
	int        flag_errors;
	int        other_errors;
	int        cycle_cnt;
	int        limit;
	int        ack_rises;
	int        req_rises;
	logic      ack_q;
	logic      req_q;

	wb_top #(
		.RAM_WORDS   (RAM_WORDS),
		.WAIT_STATES (WAIT_STATES),
		.VECTOR      (VECTOR)
	) u_wb_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.ack       (ack),
		.kind      (kind),
		.rd        (rd),
		.ra        (ra),
		.rd_hi     (rd_hi),
		.op_a      (op_a),
		.op_b      (op_b),
		.set_flags (set_flags),
		.base_wb   (base_wb),
		.dbg_addr  (dbg_addr),
		.dbg_data  (dbg_data),
		.flags     (flags)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	task automatic check_word(input string name, input word got, input word expected);
		if (got !== expected) begin
			$display("FAILED %s: got 0x%08h expected 0x%08h", name, got, expected);
			value_errors++;
		end
	endtask

	task automatic check_flags(input psr_flags got, input psr_flags expected);
		if (got !== expected) begin
			$display("FAILED flags: got 0x%01h expected 0x%01h", got, expected);
			flag_errors++;
		end
	endtask

	task automatic load_trace();
		int        fd;
		int        cnt;
		string     line;
		word       f_gap, f_kind, f_rd, f_ra, f_hi, f_a, f_b, f_sf, f_bw, f_n;
		word       f_r0, f_v0, f_r1, f_v1, f_fl;
		trace_line t;
		fd = $fopen("verification/wb_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file verification/wb_trace.txt");
			other_errors++;
		end else begin
			while (!$feof(fd)) begin
				if ($fgets(line, fd) != 0) begin
					cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						f_gap, f_kind, f_rd, f_ra, f_hi, f_a, f_b, f_sf, f_bw, f_n,
						f_r0, f_v0, f_r1, f_v1, f_fl);
					// Comment and blank lines do not parse.
					if (cnt == 15) begin
						t.gap       = f_gap[7:0];
						t.kind      = f_kind[2:0];
						t.rd        = f_rd[3:0];
						t.ra        = f_ra[3:0];
						t.rd_hi     = f_hi[3:0];
						t.a         = f_a;
						t.b         = f_b;
						t.set_flags = f_sf[0];
						t.base_wb   = f_bw[0];
						t.n_chk     = f_n[1:0];
						t.chk0_reg  = f_r0[3:0];
						t.chk0_val  = f_v0;
						t.chk1_reg  = f_r1[3:0];
						t.chk1_val  = f_v1;
						t.exp_flags = f_fl[3:0];
						trace.push_back(t);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_line(input trace_line t);
		// Idle gap with req low.
		repeat (t.gap) @(negedge clk);
		if (t.kind != CHECK_ONLY) begin
			kind      = op_kind'(t.kind);
			rd        = t.rd;
			ra        = t.ra;
			rd_hi     = t.rd_hi;
			op_a      = t.a;
			op_b      = t.b;
			set_flags = t.set_flags;
			base_wb   = t.base_wb;
			req       = 1'b1;
			@(negedge clk);
			while (!ack) @(negedge clk);
			req = 1'b0;
			@(negedge clk);
			while (ack) @(negedge clk);
		end
		if (t.n_chk > 2'd0) begin
			dbg_addr = t.chk0_reg;
			@(negedge clk);
			check_word($sformatf("r%0d", t.chk0_reg), dbg_data, t.chk0_val);
		end
		if (t.n_chk > 2'd1) begin
			dbg_addr = t.chk1_reg;
			@(negedge clk);
			check_word($sformatf("r%0d", t.chk1_reg), dbg_data, t.chk1_val);
		end
		check_flags(flags, t.exp_flags);
	endtask

	// Handshake order, from values seen just before each rising edge.
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack_q <= 1'b0;
			req_q <= 1'b0;
		end else begin
			if (req && !req_q)
				req_rises++;
			if (ack && !ack_q) begin
				ack_rises++;
				if (!req_q) begin
					$display("Handshake error: ack rose while req was low");
					other_errors++;
				end
				if (ack_rises > req_rises) begin
					$display("Handshake error: ack rose for an operation never requested");
					other_errors++;
				end
			end
			if (!ack && ack_q && req_q) begin
				$display("Handshake error: ack fell while req was still high");
				other_errors++;
			end
			ack_q <= ack;
			req_q <= req;
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (limit > 0 && cycle_cnt >= limit) begin
			$display("Timeout: ack did not arrive within %0d cycles", limit);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		rst_n     = 1'b0;
		req       = 1'b0;
		kind      = OP_ADD;
		rd        = '0;
		ra        = '0;
		rd_hi     = '0;
		op_a      = '0;
		op_b      = '0;
		set_flags = 1'b0;
		base_wb   = 1'b0;
		dbg_addr  = '0;
		load_trace();
		if (trace.size() == 0) begin
			$display("The trace holds no operations");
			other_errors++;
		end
		limit = trace.size() * (12 + 2 * WAIT_STATES) + 100;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		foreach (trace[i])
			run_line(trace[i]);
		if (ack_rises != req_rises) begin
			$display("Handshake error: %0d requests but %0d acks", req_rises, ack_rises);
			other_errors++;
		end
		$display("Errors: value %0d, flags %0d, handshake and trace %0d",
			value_errors, flag_errors, other_errors);
		if (value_errors + flag_errors + other_errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* verification/wb_trace.txt */
# gap kind rd ra rd_hi op_a op_b set_flags base_wb n_chk reg0 val0 reg1 val1 nzcv, all hex
# kind: 0 add, 1 sub, 2 load, 3 store, 4 mull, 5 swi, 7 read registers only
0 0 1 0 0 7fffffff 00000001 1 0 1 1 80000000 0 00000000 9
1 0 2 0 0 ffffffff 00000001 1 0 1 2 00000000 0 00000000 6
0 0 3 0 0 00000010 00000020 0 0 1 3 00000030 0 00000000 6
2 1 4 0 0 00000005 00000007 1 0 1 4 fffffffe 0 00000000 8
0 1 0 0 0 00001234 00001234 1 0 1 0 00000000 0 00000000 6
0 1 0 0 0 00000100 00000001 0 0 1 0 000000ff 0 00000000 6
3 0 5 0 0 12345678 00000000 0 0 1 5 12345678 0 00000000 6
0 3 5 6 0 00000010 00000004 0 1 2 6 00000014 5 12345678 6
1 2 7 8 0 00000050 00000004 0 1 2 7 12345678 8 00000054 6
0 3 1 a 0 00000020 00000003 0 0 1 a 00000000 0 00000000 6
4 2 9 a 0 00000023 00000000 0 0 2 9 80000000 a 00000000 6
0 4 b 0 c ffffffff ffffffff 0 0 2 b 00000001 c fffffffe 6
1 4 b 0 c 00010000 00010000 0 0 2 b 00000000 c 00000001 6
0 4 d 0 9 12345678 00000010 0 0 2 d 23456780 9 00000001 6
2 5 0 0 0 00000124 00000000 0 0 2 e 00000124 f 00000008 6
0 7 0 0 0 00000000 00000000 0 0 2 d 23456780 1 80000000 6
0 7 0 0 0 00000000 00000000 0 0 2 0 000000ff 5 12345678 6
1 0 2 0 0 40000000 40000000 1 0 1 2 80000000 0 00000000 9
0 7 0 0 0 00000000 00000000 0 0 2 e 00000124 3 00000030 9

/* vlog.f */
hdl/wb_pkg.sv
hdl/op_intake.sv
hdl/exec_sequencer.sv
hdl/writeback_control.sv
hdl/data_ram.sv
hdl/reg_file.sv
hdl/wb_top.sv
verification/tb_wb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary -f vlog.f --top-module tb_wb -o tb_wb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_wb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Test completed successfully"; then
	exit 0
fi
exit 1
